// ==== source/shader_pkg.sv ====
`default_nettype none

package shader_pkg;

	// lanes served by one vector memory instruction
	localparam int shader_lanes = 4;

	typedef logic [31:0] word;
	typedef logic [shader_lanes-1:0] lane_mask;
	typedef logic [1:0] lane_no;

	typedef logic [2:0] group_id;
	typedef logic [3:0] vgpr_num;

	// instructions that may wait for their memory responses at once
	localparam int tag_depth = 8;

	// in-flight record, laid out as {group, vgpr, mask}
	typedef logic [$bits(group_id)+$bits(vgpr_num)+$bits(lane_mask)-1:0] mem_tag;

endpackage

`default_nettype wire

// ==== source/axi_bus_pkg.sv ====
`default_nettype none

package axi_bus_pkg;

	typedef logic [7:0] axi_len;
	typedef logic [2:0] axi_size;
	typedef logic [1:0] axi_burst;
	typedef logic [3:0] axi_strb;

	// 4 bytes per beat
	localparam axi_size beat_size_word = 3'b010;

	localparam axi_burst burst_incr = 2'b01;

endpackage

`default_nettype wire

// ==== source/lane_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_serializer (
	input  logic               clk,
	input  logic               load,
	input  logic               shift,
	input  shader_pkg::word    lanes[shader_pkg::shader_lanes],
	input  shader_pkg::lane_mask mask,
	output shader_pkg::word    data,
	output logic               last,
	output logic               enable
);

	import shader_pkg::*;

	word      buf_lanes[shader_lanes];
	lane_mask buf_mask;
	lane_no   count;

	// lane 0 of the buffer is always the lane on the bus
	assign data = buf_lanes[0];
	assign enable = buf_mask[0];
	assign last = &count;

	always_ff @(posedge clk) begin
		if (load) begin
			buf_lanes <= lanes;
			buf_mask <= mask;
			count <= '0;
		end else if (shift) begin
			for (int i = 0; i < shader_lanes - 1; i++) begin
				buf_lanes[i] <= buf_lanes[i + 1];
			end
			buf_mask <= buf_mask >> 1;
			count <= count + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== source/lane_deserializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_deserializer (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            shift,
	input  shader_pkg::word data,
	input  logic            last,
	input  logic            done,
	output shader_pkg::word lanes[shader_pkg::shader_lanes],
	output logic            full
);

	import shader_pkg::*;

	// beats enter at the top, so after a full pass lane 0 holds the first beat
	always_ff @(posedge clk) begin
		if (shift) begin
			for (int i = 0; i < shader_lanes - 1; i++) begin
				lanes[i] <= lanes[i + 1];
			end
			lanes[shader_lanes - 1] <= data;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			full <= 1'b0;
		end else if (done) begin
			full <= 1'b0;
		end else if (shift) begin
			full <= last;
		end
	end

endmodule

`default_nettype wire

// ==== source/tag_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module tag_fifo (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               push,
	input  shader_pkg::mem_tag push_tag,
	input  logic               pop,
	output shader_pkg::mem_tag pop_tag,
	output logic               empty,
	output logic               full
);

	import shader_pkg::*;

	mem_tag entries[tag_depth];

	logic [$clog2(tag_depth)-1:0] wr_ptr;
	logic [$clog2(tag_depth)-1:0] rd_ptr;
	logic [$clog2(tag_depth):0]   count;
	logic do_push;
	logic do_pop;

	assign do_push = push & ~full;
	assign do_pop = pop & ~empty;

	assign empty = count == '0;
	assign full = count == tag_depth;
	assign pop_tag = entries[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			entries[wr_ptr] <= push_tag;
		end
	end

	// the depth is a power of two, so the pointers wrap on their own
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + do_push - do_pop;
		end
	end

endmodule

`default_nettype wire

// ==== source/addr_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module addr_issue (
	input  logic                 clk,
	input  logic                 rst_n,
	input  shader_pkg::word      lanes[shader_pkg::shader_lanes],
	input  logic                 load_valid,
	output logic                 load,
	output shader_pkg::word      addr,
	output axi_bus_pkg::axi_len  len,
	output axi_bus_pkg::axi_size size,
	output axi_bus_pkg::axi_burst burst,
	output logic                 valid,
	input  logic                 ready
);

	import axi_bus_pkg::*;

	logic active;
	logic take;
	logic beat;
	logic last;

	// every lane is its own single-beat transaction
	assign len = '0;
	assign size = beat_size_word;
	assign burst = burst_incr;

	assign valid = active;
	assign beat = active & ready;
	assign load = ~active | (beat & last);
	assign take = load & load_valid;

	lane_serializer addr_stream (
		.clk    (clk),
		.load   (take),
		.shift  (beat),
		.lanes  (lanes),
		.mask   ('1),
		.data   (addr),
		.last   (last),
		.enable ()
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
		end else if (load) begin
			active <= load_valid;
		end
	end

	a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
		valid && !ready |=> valid && $stable(addr));

endmodule

`default_nettype wire

// ==== source/shader_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module shader_mem (
	input  logic                  clk,
	input  logic                  rst_n,

	input  logic                  in_valid,
	output logic                  in_ready,
	input  logic                  op_load,
	input  shader_pkg::group_id   in_group,
	input  shader_pkg::vgpr_num   in_vgpr,
	input  shader_pkg::lane_mask  in_mask,
	input  shader_pkg::word       in_addr[shader_pkg::shader_lanes],
	input  shader_pkg::word       in_data[shader_pkg::shader_lanes],

	output shader_pkg::word       araddr,
	output axi_bus_pkg::axi_len   arlen,
	output axi_bus_pkg::axi_size  arsize,
	output axi_bus_pkg::axi_burst arburst,
	output logic                  arvalid,
	input  logic                  arready,
	input  shader_pkg::word       rdata,
	input  logic                  rlast,
	input  logic                  rvalid,
	output logic                  rready,

	output shader_pkg::word       awaddr,
	output axi_bus_pkg::axi_len   awlen,
	output axi_bus_pkg::axi_size  awsize,
	output axi_bus_pkg::axi_burst awburst,
	output logic                  awvalid,
	input  logic                  awready,
	output shader_pkg::word       wdata,
	output axi_bus_pkg::axi_strb  wstrb,
	output logic                  wlast,
	output logic                  wvalid,
	input  logic                  wready,
	input  logic                  bvalid,
	output logic                  bready,

	output logic                  wb_valid,
	input  logic                  wb_ready,
	output shader_pkg::group_id   wb_group,
	output shader_pkg::vgpr_num   wb_vgpr,
	output shader_pkg::lane_mask  wb_mask,
	output shader_pkg::word       wb_lanes[shader_pkg::shader_lanes],
	output logic                  wb_load
);

	import shader_pkg::*;
	import axi_bus_pkg::*;

	logic   ar_load, aw_load, w_idle, w_shift, w_enable, w_end;
	logic   accept, ld_take, st_take;
	logic   rd_push, rd_pop, rd_empty, rd_full;
	logic   wr_push, wr_pop, wr_empty, wr_full;
	mem_tag in_tag, rd_tag, wr_tag, wb_tag;
	logic   r_shift, r_last, r_full;
	lane_no r_count, b_count;
	logic   b_take, store_pend, store_lock, sel_read;

	// **********************************************************************
	// instruction acceptance
	// **********************************************************************

	assign w_idle = ~wvalid | (w_end & wready);
	assign in_ready = op_load ? ar_load & ~rd_full : aw_load & w_idle & ~wr_full;

	assign accept = in_valid & in_ready;
	assign ld_take = accept & op_load;
	assign st_take = accept & ~op_load;

	assign in_tag = {in_group, in_vgpr, in_mask};
	assign rd_push = ld_take;
	assign wr_push = st_take;

	addr_issue ar_issue (
		.clk        (clk),
		.rst_n      (rst_n),
		.lanes      (in_addr),
		.load_valid (ld_take),
		.load       (ar_load),
		.addr       (araddr),
		.len        (arlen),
		.size       (arsize),
		.burst      (arburst),
		.valid      (arvalid),
		.ready      (arready)
	);

	addr_issue aw_issue (
		.clk        (clk),
		.rst_n      (rst_n),
		.lanes      (in_addr),
		.load_valid (st_take),
		.load       (aw_load),
		.addr       (awaddr),
		.len        (awlen),
		.size       (awsize),
		.burst      (awburst),
		.valid      (awvalid),
		.ready      (awready)
	);

	// **********************************************************************
	// write data and read return streams
	// **********************************************************************

	// masked-off store lanes still send a beat, with no byte enabled
	assign w_shift = wvalid & wready;
	assign wstrb = {$bits(axi_strb){w_enable}};

	// every W beat closes its own single-beat burst
	assign wlast = 1'b1;

	lane_serializer w_stream (
		.clk    (clk),
		.load   (st_take),
		.shift  (w_shift),
		.lanes  (in_data),
		.mask   (in_mask),
		.data   (wdata),
		.last   (w_end),
		.enable (w_enable)
	);

	assign rready = ~r_full | rd_pop;
	assign r_shift = rvalid & rready;
	assign r_last = rlast & (&r_count);

	lane_deserializer r_stream (
		.clk   (clk),
		.rst_n (rst_n),
		.shift (r_shift),
		.data  (rdata),
		.last  (r_last),
		.done  (rd_pop),
		.lanes (wb_lanes),
		.full  (r_full)
	);

	tag_fifo rd_tags (
		.clk      (clk),
		.rst_n    (rst_n),
		.push     (rd_push),
		.push_tag (in_tag),
		.pop      (rd_pop),
		.pop_tag  (rd_tag),
		.empty    (rd_empty),
		.full     (rd_full)
	);

	tag_fifo wr_tags (
		.clk      (clk),
		.rst_n    (rst_n),
		.push     (wr_push),
		.push_tag (in_tag),
		.pop      (wr_pop),
		.pop_tag  (wr_tag),
		.empty    (wr_empty),
		.full     (wr_full)
	);

	// **********************************************************************
	// store responses and writeback selection
	// **********************************************************************

	// a finished store waits in store_pend, which holds off further B responses
	assign bready = ~store_pend;
	assign b_take = bvalid & bready;

	// once a store is on the port it stays there until taken
	assign sel_read = r_full & ~store_lock;
	assign wb_valid = r_full | store_pend;
	assign wb_load = sel_read;
	assign wb_tag = sel_read ? rd_tag : wr_tag;
	assign {wb_group, wb_vgpr, wb_mask} = wb_tag;

	assign rd_pop = wb_ready & sel_read & ~rd_empty;
	assign wr_pop = wb_ready & ~sel_read & store_pend & ~wr_empty;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wvalid <= 1'b0;
			r_count <= '0;
			b_count <= '0;
			store_pend <= 1'b0;
			store_lock <= 1'b0;
		end else begin
			wvalid <= st_take | (wvalid & ~(w_end & wready));
			if (r_shift) begin
				r_count <= r_count + 1'b1;
			end
			if (b_take) begin
				b_count <= b_count + 1'b1;
			end
			if (b_take && &b_count) begin
				store_pend <= 1'b1;
			end else if (wr_pop) begin
				store_pend <= 1'b0;
			end
			store_lock <= store_pend & ~sel_read & ~wb_ready;
		end
	end

	a_no_full_push: assert property (@(posedge clk) disable iff (!rst_n)
		!(rd_push && rd_full) && !(wr_push && wr_full));

	a_wvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
		wvalid && !wready |=> wvalid && $stable(wdata));

endmodule

`default_nettype wire

// ==== sim/axi_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model (
	input  logic                 clk,
	input  logic                 rst_n,
	input  shader_pkg::word      araddr,
	input  logic                 arvalid,
	output logic                 arready,
	output shader_pkg::word      rdata,
	output logic                 rlast,
	output logic                 rvalid,
	input  logic                 rready,
	input  shader_pkg::word      awaddr,
	input  logic                 awvalid,
	output logic                 awready,
	input  shader_pkg::word      wdata,
	input  axi_bus_pkg::axi_strb wstrb,
	input  logic                 wvalid,
	output logic                 wready,
	output logic                 bvalid,
	input  logic                 bready
);

	import shader_pkg::*;
	import axi_bus_pkg::*;

	localparam int mem_words = 64;

	word     mem[mem_words];
	word     ar_q[$];
	word     aw_q[$];
	word     wd_q[$];
	axi_strb ws_q[$];
	int      b_pend;
	int      seed;
	word     a;
	word     d;
	axi_strb s;
	logic    n_rvalid;
	logic    n_bvalid;
	word     n_rdata;

	initial begin
		seed = 87379;
		b_pend = 0;
		for (int i = 0; i < mem_words; i++) begin
			mem[i] = (i * 32'h9e37_79b1) ^ 32'h0bad_cafe;
		end
		arready = 1'b0;
		awready = 1'b0;
		wready = 1'b0;
		rvalid = 1'b0;
		bvalid = 1'b0;
		rdata = '0;
		rlast = 1'b1;
	end

	// handshakes are sampled on the edge, new outputs appear 1 ns later
	always @(posedge clk) begin
		if (rst_n) begin
			if (arvalid && arready) ar_q.push_back(araddr);
			if (awvalid && awready) aw_q.push_back(awaddr);
			if (wvalid && wready) begin
				wd_q.push_back(wdata);
				ws_q.push_back(wstrb);
			end
			while (aw_q.size() > 0 && wd_q.size() > 0) begin
				a = aw_q.pop_front();
				d = wd_q.pop_front();
				s = ws_q.pop_front();
				for (int b = 0; b < 4; b++) begin
					if (s[b]) mem[a[7:2]][b*8 +: 8] = d[b*8 +: 8];
				end
				b_pend++;
			end
			n_rvalid = rvalid && !rready;
			n_rdata = rdata;
			if (!n_rvalid && ar_q.size() > 0 && ($random(seed) & 3) != 0) begin
				a = ar_q.pop_front();
				n_rvalid = 1'b1;
				n_rdata = mem[a[7:2]];
			end
			n_bvalid = bvalid && !bready;
			if (!n_bvalid && b_pend > 0 && ($random(seed) & 3) != 0) begin
				n_bvalid = 1'b1;
				b_pend--;
			end
			#1;
			rvalid = n_rvalid;
			rdata = n_rdata;
			bvalid = n_bvalid;
			arready = ($random(seed) & 3) != 0;
			awready = ($random(seed) & 3) != 0;
			wready = ($random(seed) & 3) != 0;
		end
	end

endmodule

`default_nettype wire

// ==== sim/tb_shader_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_shader_mem;

	import shader_pkg::*;
	import axi_bus_pkg::*;

	localparam int rand_instr = 40;
	localparam int num_instr = tag_depth + rand_instr;

	logic clk = 1'b0;
	logic rst_n;
	logic in_valid, in_ready, op_load;
	group_id in_group;
	vgpr_num in_vgpr;
	lane_mask in_mask;
	word in_addr[shader_lanes];
	word in_data[shader_lanes];
	word araddr, rdata, awaddr, wdata;
	axi_len arlen, awlen;
	axi_size arsize, awsize;
	axi_burst arburst, awburst;
	axi_strb wstrb;
	logic arvalid, arready, rlast, rvalid, rready;
	logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;
	logic wb_valid, wb_ready, wb_load;
	group_id wb_group;
	vgpr_num wb_vgpr;
	lane_mask wb_mask;
	word wb_lanes[shader_lanes];

	int seed = 87379;
	logic hold_wb = 1'b1;
	word ref_mem[64];
	mem_tag ld_tag_q[$];
	logic [127:0] ld_data_q[$];
	mem_tag st_tag_q[$];
	int ld_sent = 0, ld_done = 0, st_sent = 0, st_done = 0;
	logic held = 1'b0;
	logic [11:0] prev_fields;
	logic [127:0] prev_lanes;

	shader_mem dut (.*);

	axi_mem_model memory (
		.clk(clk), .rst_n(rst_n), .araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rlast(rlast), .rvalid(rvalid), .rready(rready),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready), .wdata(wdata),
		.wstrb(wstrb), .wvalid(wvalid), .wready(wready), .bvalid(bvalid), .bready(bready)
	);

	always #2 clk = ~clk;

	task automatic abort_run(input string msg);
		$display("%0t: %s", $time, msg);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [127:0] exp,
			input logic [127:0] act);
		$display("FAILED at %0t: %s expected %0h, got %0h", $time, name, exp, act);
		$display("Test FAILED");
		$fatal(1);
	endtask

	function automatic logic [127:0] flat_lanes();
		return {wb_lanes[3], wb_lanes[2], wb_lanes[1], wb_lanes[0]};
	endfunction

	// one instruction, held on the port until the DUT takes it
	task automatic send_instr(input logic is_load);
		logic [127:0] exp;
		while (is_load ? st_sent != st_done : ld_sent != ld_done) @(posedge clk);
		@(posedge clk);
		#1;
		for (int i = 0; i < shader_lanes; i++) begin
			in_addr[i] = word'(($random(seed) & 63) << 2);
			in_data[i] = $random(seed);
		end
		in_mask = $random(seed);
		in_group = $random(seed);
		in_vgpr = $random(seed);
		op_load = is_load;
		in_valid = 1'b1;
		do @(posedge clk); while (!in_ready);
		if (is_load) begin
			for (int i = 0; i < shader_lanes; i++) exp[i*32 +: 32] = ref_mem[in_addr[i][7:2]];
			ld_tag_q.push_back({in_group, in_vgpr, in_mask});
			ld_data_q.push_back(exp);
			ld_sent++;
		end else begin
			for (int i = 0; i < shader_lanes; i++) begin
				if (in_mask[i]) ref_mem[in_addr[i][7:2]] = in_data[i];
			end
			st_tag_q.push_back({in_group, in_vgpr, in_mask});
			st_sent++;
		end
		#1 in_valid = 1'b0;
	endtask

	always @(posedge clk) begin
		#1 wb_ready = hold_wb ? 1'b0 : (($random(seed) & 3) != 0);
	end

	// **********************************************************************
	// memory bus field checks
	// **********************************************************************

	// single-beat INCR bursts of 4-byte words, so every W beat is a last beat
	always @(posedge clk) begin
		if (rst_n) begin
			if (arvalid) begin
				assert (arlen == 8'd0) else report_mismatch("arlen", 8'd0, arlen);
				assert (arsize == 3'b010) else report_mismatch("arsize", 3'b010, arsize);
				assert (arburst == 2'b01) else report_mismatch("arburst", 2'b01, arburst);
			end
			if (awvalid) begin
				assert (awlen == 8'd0) else report_mismatch("awlen", 8'd0, awlen);
				assert (awsize == 3'b010) else report_mismatch("awsize", 3'b010, awsize);
				assert (awburst == 2'b01) else report_mismatch("awburst", 2'b01, awburst);
			end
			if (wvalid) begin
				assert (wlast) else report_mismatch("wlast", 1'b1, wlast);
			end
		end
	end

	// **********************************************************************
	// writeback checks
	// **********************************************************************

	always @(posedge clk) begin
		mem_tag t;
		logic [127:0] exp;
		if (rst_n) begin
			if (held) begin
				assert (wb_valid) else abort_run("wb_valid dropped before wb_ready");
				assert ({wb_group, wb_vgpr, wb_mask, wb_load} == prev_fields)
					else report_mismatch("wb fields", prev_fields,
						{wb_group, wb_vgpr, wb_mask, wb_load});
				if (wb_load) begin
					assert (flat_lanes() == prev_lanes)
						else report_mismatch("wb_lanes", prev_lanes, flat_lanes());
				end
			end
			if (wb_valid && wb_ready) begin
				if (wb_load) begin
					assert (ld_tag_q.size() > 0)
						else abort_run("load completion with no load in flight");
					t = ld_tag_q.pop_front();
					exp = ld_data_q.pop_front();
					for (int i = 0; i < shader_lanes; i++) begin
						if (t[i]) begin
							assert (wb_lanes[i] == exp[i*32 +: 32])
								else report_mismatch($sformatf("wb_lanes[%0d]", i),
									exp[i*32 +: 32], wb_lanes[i]);
						end
					end
					ld_done++;
				end else begin
					assert (st_tag_q.size() > 0)
						else abort_run("store completion with no store in flight");
					t = st_tag_q.pop_front();
					st_done++;
				end
				assert ({wb_group, wb_vgpr, wb_mask} == t)
					else report_mismatch("wb_group/wb_vgpr/wb_mask", t,
						{wb_group, wb_vgpr, wb_mask});
			end
			held = wb_valid && !wb_ready;
			prev_fields = {wb_group, wb_vgpr, wb_mask, wb_load};
			prev_lanes = flat_lanes();
		end
	end

	initial begin
		#(num_instr * 200);
		abort_run("watchdog expired before all completions arrived");
	end

	initial begin
		for (int i = 0; i < 64; i++) ref_mem[i] = (i * 32'h9e37_79b1) ^ 32'h0bad_cafe;
		rst_n = 1'b0;
		in_valid = 1'b0;
		op_load = 1'b0;
		in_group = '0;
		in_vgpr = '0;
		in_mask = '0;
		wb_ready = 1'b0;
		for (int i = 0; i < shader_lanes; i++) begin
			in_addr[i] = '0;
			in_data[i] = '0;
		end
		repeat (5) @(posedge clk);
		assert (!arvalid && !awvalid && !wvalid && !wb_valid)
			else abort_run("a valid output is high during reset");
		#1 rst_n = 1'b1;
		@(posedge clk);
		assert (!arvalid && !awvalid && !wvalid && !wb_valid)
			else abort_run("a valid output is high right after reset");

		// fill the read tag queue while writeback is blocked
		repeat (tag_depth) send_instr(1'b1);
		op_load = 1'b1;
		repeat (10) begin
			@(posedge clk);
			assert (!in_ready) else abort_run("in_ready high with a full tag queue");
		end
		hold_wb = 1'b0;

		repeat (rand_instr) send_instr(($random(seed) & 1) == 1);
		while (ld_sent != ld_done || st_sent != st_done) @(posedge clk);
		repeat (5) @(posedge clk);
		if (!wb_valid) begin
			$display("Test OK");
			$finish;
		end else begin
			abort_run("a completion is still pending after all expected ones arrived");
		end
	end

endmodule

`default_nettype wire

// ==== sim.f ====
source/shader_pkg.sv
source/axi_bus_pkg.sv
source/lane_serializer.sv
source/lane_deserializer.sv
source/tag_fifo.sv
source/addr_issue.sv
source/shader_mem.sv
sim/axi_mem_model.sv
sim/tb_shader_mem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_shader_mem \
	-f sim.f -Mdir obj_dir -o sim_bin > build.log 2>&1 \
	&& ./obj_dir/sim_bin > sim.log 2>&1
grep -q "^Test OK$" sim.log && echo "simulation passed" \
	|| { echo "simulation failed, see build.log and sim.log"; exit 1; }
